//--- logic/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------

`define CPU_DATA_W          8
`define CPU_ADDR_W          16

// ----------------------------------------------------------------------
// Vectors and opcodes the sequencer treats specially
// ----------------------------------------------------------------------

// Low byte of the reset target, high byte follows
`define CPU_RESET_VECTOR    16'hFFFC
`define CPU_OP_JMP_ABS      8'h4C

// Bit positions in P
`define CPU_FLAG_N          7
`define CPU_FLAG_V          6
`define CPU_FLAG_Z          1
`define CPU_FLAG_C          0

`endif

//--- logic/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

    // ------------------------------------------------------------------
    // Two views of one opcode byte
    // ------------------------------------------------------------------

    typedef struct packed {
        logic [2:0] aaa;        // Operation within group
        logic [2:0] bbb;        // Addressing mode
        logic [1:0] cc;         // Instruction group
    } op_grp_t;

    typedef struct packed {
        logic [1:0] flag;       // 00 N, 01 V, 10 C, 11 Z
        logic       want;       // Taken when flag equals this
        logic [4:0] pattern;    // 5'b10000 marks a branch
    } op_br_t;

    typedef union packed {
        op_grp_t grp;
        op_br_t  br;
    } opcode_u;

    typedef enum logic [2:0] {
        IMPLIED, IMMEDIATE, ZERO_PAGE, ABSOLUTE, RELATIVE, JUMP
    } addr_mode_e;

    typedef enum logic [3:0] {
        ALU_OR, ALU_AND, ALU_EOR, ALU_ADC, ALU_PASS, ALU_CMP, ALU_SBC,
        ALU_INC, ALU_DEC, ALU_SET_C, ALU_CLR_C, ALU_CLR_V
    } alu_op_e;

    typedef enum logic [1:0] {REG_A, REG_X, REG_Y, REG_S} reg_sel_e;

    typedef struct packed {
        opcode_u    opcode;
        addr_mode_e mode;
        alu_op_e    alu_op;
        reg_sel_e   src_a;
        reg_sel_e   src_b;      // Ignored when use_mem is set
        logic       use_mem;    // Operand b from the data bus
        reg_sel_e   dst;
        logic       reg_wr;
        logic       flag_wr;
        logic       is_store;
    } ctrl_t;

    typedef struct packed {
        logic [`CPU_DATA_W-1:0] a;
        logic [`CPU_DATA_W-1:0] x;
        logic [`CPU_DATA_W-1:0] y;
        logic [`CPU_DATA_W-1:0] s;
    } regs_t;

    typedef struct packed {
        logic [`CPU_DATA_W-1:0] result;
        logic [`CPU_DATA_W-1:0] p;      // Flags after the operation
    } alu_out_t;

endpackage

//--- logic/cpu_decode.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_decode (
    input  logic [`CPU_DATA_W-1:0] din,
    output cpu_pkg::ctrl_t         ctrl
);

    cpu_pkg::opcode_u    op;
    cpu_pkg::addr_mode_e mem_mode;
    cpu_pkg::reg_sel_e   idx;        // X for cc=10, Y for cc=00
    logic                is_st;      // aaa=100 stores in every group
    logic                mem_ok;     // Supported operand mode

    // Implied instruction with register operands
    function automatic cpu_pkg::ctrl_t imp(input cpu_pkg::alu_op_e f,
                                           input cpu_pkg::reg_sel_e b,
                                           input cpu_pkg::reg_sel_e d,
                                           input logic fw);
        cpu_pkg::ctrl_t r;
        r = '0;
        r.alu_op  = f;
        r.src_b   = b;
        r.dst     = d;
        r.reg_wr  = !(f inside {cpu_pkg::ALU_SET_C, cpu_pkg::ALU_CLR_C, cpu_pkg::ALU_CLR_V});
        r.flag_wr = fw;
        return r;
    endfunction

    assign op    = din;
    assign is_st = (op.grp.aaa == 3'b100);
    assign idx   = (op.grp.cc == 2'b10) ? cpu_pkg::REG_X : cpu_pkg::REG_Y;

    always_comb begin
        case (op.grp.bbb)
            3'b001:  mem_mode = cpu_pkg::ZERO_PAGE;
            3'b011:  mem_mode = cpu_pkg::ABSOLUTE;
            default: mem_mode = cpu_pkg::IMMEDIATE;
        endcase
        // Immediate sits at bbb=010 in group one, bbb=000 for LDX/LDY
        mem_ok = (op.grp.bbb == 3'b001) || (op.grp.bbb == 3'b011) ||
                 (!is_st && op.grp.bbb == ((op.grp.cc == 2'b01) ? 3'b010 : 3'b000));
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = cpu_pkg::ALU_PASS;
        if (op.br.pattern == 5'b10000) begin
            ctrl.mode = cpu_pkg::RELATIVE;                  // Bxx
        end else if (din == `CPU_OP_JMP_ABS) begin
            ctrl.mode = cpu_pkg::JUMP;
        end else if (op.grp.cc == 2'b01 && mem_ok) begin
            ctrl.mode     = mem_mode;                       // Group one, A is operand a
            ctrl.use_mem  = !is_st;
            ctrl.reg_wr   = !is_st && (op.grp.aaa != 3'b110);
            ctrl.flag_wr  = !is_st;
            ctrl.is_store = is_st;
            case (op.grp.aaa)
                3'b000:  ctrl.alu_op = cpu_pkg::ALU_OR;
                3'b001:  ctrl.alu_op = cpu_pkg::ALU_AND;
                3'b010:  ctrl.alu_op = cpu_pkg::ALU_EOR;
                3'b011:  ctrl.alu_op = cpu_pkg::ALU_ADC;
                3'b110:  ctrl.alu_op = cpu_pkg::ALU_CMP;
                3'b111:  ctrl.alu_op = cpu_pkg::ALU_SBC;
                default: ctrl.alu_op = cpu_pkg::ALU_PASS;   // STA, LDA
            endcase
        end else if (op.grp.cc != 2'b11 && op.grp.aaa[2:1] == 2'b10 && mem_ok) begin
            ctrl.mode     = mem_mode;                       // LDX/LDY/STX/STY
            ctrl.src_b    = idx;
            ctrl.dst      = idx;
            ctrl.use_mem  = !is_st;
            ctrl.reg_wr   = !is_st;
            ctrl.flag_wr  = !is_st;
            ctrl.is_store = is_st;
        end else begin
            case (din)
                8'hAA: ctrl = imp(cpu_pkg::ALU_PASS, cpu_pkg::REG_A, cpu_pkg::REG_X, 1'b1);
                8'hA8: ctrl = imp(cpu_pkg::ALU_PASS, cpu_pkg::REG_A, cpu_pkg::REG_Y, 1'b1);
                8'h8A: ctrl = imp(cpu_pkg::ALU_PASS, cpu_pkg::REG_X, cpu_pkg::REG_A, 1'b1);
                8'h98: ctrl = imp(cpu_pkg::ALU_PASS, cpu_pkg::REG_Y, cpu_pkg::REG_A, 1'b1);
                8'h9A: ctrl = imp(cpu_pkg::ALU_PASS, cpu_pkg::REG_X, cpu_pkg::REG_S, 1'b0);
                8'hBA: ctrl = imp(cpu_pkg::ALU_PASS, cpu_pkg::REG_S, cpu_pkg::REG_X, 1'b1);
                8'hE8: ctrl = imp(cpu_pkg::ALU_INC, cpu_pkg::REG_X, cpu_pkg::REG_X, 1'b1);
                8'hC8: ctrl = imp(cpu_pkg::ALU_INC, cpu_pkg::REG_Y, cpu_pkg::REG_Y, 1'b1);
                8'hCA: ctrl = imp(cpu_pkg::ALU_DEC, cpu_pkg::REG_X, cpu_pkg::REG_X, 1'b1);
                8'h88: ctrl = imp(cpu_pkg::ALU_DEC, cpu_pkg::REG_Y, cpu_pkg::REG_Y, 1'b1);
                8'h18: ctrl = imp(cpu_pkg::ALU_CLR_C, cpu_pkg::REG_A, cpu_pkg::REG_A, 1'b1);
                8'h38: ctrl = imp(cpu_pkg::ALU_SET_C, cpu_pkg::REG_A, cpu_pkg::REG_A, 1'b1);
                8'hB8: ctrl = imp(cpu_pkg::ALU_CLR_V, cpu_pkg::REG_A, cpu_pkg::REG_A, 1'b1);
                default: ;                                  // Two-cycle no-op
            endcase
        end
        ctrl.opcode = op;
    end

endmodule

//--- logic/cpu_sequencer.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_sequencer (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   ce,
    input  logic [`CPU_DATA_W-1:0] din,
    input  cpu_pkg::ctrl_t         dec_ctrl,
    input  logic [`CPU_DATA_W-1:0] p,
    input  cpu_pkg::alu_out_t      alu_out,
    output cpu_pkg::ctrl_t         ctrl,
    output logic                   exec,
    output logic [`CPU_ADDR_W-1:0] addr,
    output logic [`CPU_ADDR_W-1:0] wr_addr,
    output logic [`CPU_DATA_W-1:0] dout,
    output logic                   wreq
);

    typedef enum logic [3:0] {
        RST_LO, RST_HI, RST_JMP, FETCH, ZP, ABS_LO, ABS_HI, EXEC,
        REL, REL_TAKEN, REL_CROSS
    } state_e;

    state_e                 state;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] ea;          // Effective address
    logic [`CPU_DATA_W-1:0] tmp;         // Low byte of vector or operand
    logic                   wreq_q;
    logic                   flag;
    logic [`CPU_ADDR_W-1:0] pc_inc;
    logic [`CPU_ADDR_W-1:0] pc_rel;

    assign pc_inc  = pc + 1'b1;
    assign pc_rel  = pc_inc + {{(`CPU_ADDR_W-`CPU_DATA_W){din[`CPU_DATA_W-1]}}, din};
    assign addr    = (state == EXEC && (ctrl.mode == cpu_pkg::ZERO_PAGE ||
                      ctrl.mode == cpu_pkg::ABSOLUTE)) ? ea : pc;
    assign wr_addr = ea;                 // Held through the next FETCH
    assign exec    = (state == EXEC) && ce;
    assign wreq    = wreq_q && ce;       // No write while frozen

    // Branch condition from the br view of the opcode
    always_comb begin
        case (ctrl.opcode.br.flag)
            2'b00:   flag = p[`CPU_FLAG_N];
            2'b01:   flag = p[`CPU_FLAG_V];
            2'b10:   flag = p[`CPU_FLAG_C];
            default: flag = p[`CPU_FLAG_Z];
        endcase
    end

    // ------------------------------------------------------------------
    // Cycle FSM and PC
    // ------------------------------------------------------------------

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state  <= RST_LO;
            pc     <= '0;
            ctrl   <= '0;
            wreq_q <= 1'b0;
        end else if (ce) begin
            wreq_q <= 1'b0;                                 // One-cycle write pulse
            case (state)
                RST_LO: begin
                    pc    <= `CPU_RESET_VECTOR;
                    state <= RST_HI;
                end
                RST_HI: begin
                    pc    <= pc_inc;                        // Vector high byte next
                    state <= RST_JMP;
                end
                RST_JMP: begin
                    pc    <= {din, tmp};
                    state <= FETCH;
                end
                FETCH: begin
                    ctrl <= dec_ctrl;
                    pc   <= pc_inc;
                    case (dec_ctrl.mode)
                        cpu_pkg::ZERO_PAGE:               state <= ZP;
                        cpu_pkg::ABSOLUTE, cpu_pkg::JUMP: state <= ABS_LO;
                        cpu_pkg::RELATIVE:                state <= REL;
                        default:                          state <= EXEC;
                    endcase
                end
                ZP, ABS_LO: begin
                    pc    <= pc_inc;
                    state <= (state == ZP) ? EXEC : ABS_HI;
                end
                ABS_HI: begin
                    pc    <= (ctrl.mode == cpu_pkg::JUMP) ? {din, tmp} : pc_inc;
                    state <= (ctrl.mode == cpu_pkg::JUMP) ? FETCH : EXEC;
                end
                EXEC: begin
                    if (ctrl.mode == cpu_pkg::IMMEDIATE)
                        pc <= pc_inc;                       // Step past operand
                    wreq_q <= ctrl.is_store;
                    state  <= FETCH;
                end
                REL: begin
                    if (flag == ctrl.opcode.br.want) begin
                        pc    <= pc_rel;
                        state <= (pc_rel[`CPU_ADDR_W-1:`CPU_DATA_W] !=
                                  pc_inc[`CPU_ADDR_W-1:`CPU_DATA_W]) ? REL_CROSS : REL_TAKEN;
                    end else begin
                        pc    <= pc_inc;
                        state <= FETCH;
                    end
                end
                REL_CROSS: state <= REL_TAKEN;              // Page fix-up cycle
                default:   state <= FETCH;                  // REL_TAKEN
            endcase
        end
    end

    // Address and store data path
    always_ff @(posedge CLK) begin
        if (ce) begin
            case (state)
                RST_HI, ABS_LO: tmp <= din;
                ZP:     ea <= {{(`CPU_ADDR_W-`CPU_DATA_W){1'b0}}, din};
                ABS_HI: ea <= {din, tmp};
                EXEC:   dout <= alu_out.result;             // Used only with wreq
                default: ;
            endcase
        end
    end

endmodule

//--- logic/cpu_alu.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_alu (
    input  cpu_pkg::ctrl_t         ctrl,
    input  cpu_pkg::regs_t         regs,
    input  logic [`CPU_DATA_W-1:0] p,
    input  logic [`CPU_DATA_W-1:0] din,
    output cpu_pkg::alu_out_t      alu_out
);

    logic [`CPU_DATA_W-1:0] a;
    logic [`CPU_DATA_W-1:0] b;
    logic [`CPU_DATA_W-1:0] bb;          // b, inverted for subtract
    logic [`CPU_DATA_W-1:0] res;
    logic [`CPU_DATA_W-1:0] np;
    logic [`CPU_DATA_W:0]   sum;
    logic                   cin;
    logic                   nz;          // Update N and Z from res

    function automatic logic [`CPU_DATA_W-1:0] pick(input cpu_pkg::regs_t r,
                                                    input cpu_pkg::reg_sel_e s);
        case (s)
            cpu_pkg::REG_A: return r.a;
            cpu_pkg::REG_X: return r.x;
            cpu_pkg::REG_Y: return r.y;
            default:        return r.s;
        endcase
    endfunction

    always_comb begin
        a   = pick(regs, ctrl.src_a);
        b   = ctrl.use_mem ? din : pick(regs, ctrl.src_b);
        bb  = (ctrl.alu_op inside {cpu_pkg::ALU_SBC, cpu_pkg::ALU_CMP}) ? ~b : b;
        cin = (ctrl.alu_op == cpu_pkg::ALU_CMP) ? 1'b1 : p[`CPU_FLAG_C];
        sum = {1'b0, a} + {1'b0, bb} + cin;                 // Shared adder
        res = b;
        np  = p;
        nz  = 1'b1;
        case (ctrl.alu_op)
            cpu_pkg::ALU_OR:  res = a | b;
            cpu_pkg::ALU_AND: res = a & b;
            cpu_pkg::ALU_EOR: res = a ^ b;
            cpu_pkg::ALU_ADC, cpu_pkg::ALU_SBC: begin
                res                = sum[`CPU_DATA_W-1:0];
                np[`CPU_FLAG_C]    = sum[`CPU_DATA_W];      // Carry, or no borrow
                np[`CPU_FLAG_V]    = (a[`CPU_DATA_W-1] == bb[`CPU_DATA_W-1]) &&
                                     (sum[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);
            end
            cpu_pkg::ALU_CMP: begin
                res             = sum[`CPU_DATA_W-1:0];     // a - b, flags only
                np[`CPU_FLAG_C] = sum[`CPU_DATA_W];
            end
            cpu_pkg::ALU_INC: res = b + 1'b1;
            cpu_pkg::ALU_DEC: res = b - 1'b1;
            cpu_pkg::ALU_SET_C: {np[`CPU_FLAG_C], nz} = 2'b10;
            cpu_pkg::ALU_CLR_C: {np[`CPU_FLAG_C], nz} = 2'b00;
            cpu_pkg::ALU_CLR_V: {np[`CPU_FLAG_V], nz} = 2'b00;
            default: ;                                      // PASS
        endcase
        if (nz) begin
            np[`CPU_FLAG_N] = res[`CPU_DATA_W-1];
            np[`CPU_FLAG_Z] = (res == '0);
        end
        alu_out.result = res;
        alu_out.p      = np;
    end

endmodule

//--- logic/cpu_regfile.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_regfile (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   exec,
    input  cpu_pkg::ctrl_t         ctrl,
    input  cpu_pkg::alu_out_t      alu_out,
    output cpu_pkg::regs_t         regs,
    output logic [`CPU_DATA_W-1:0] p
);

    // ------------------------------------------------------------------
    // Write-back at the end of EXEC
    // ------------------------------------------------------------------

    always_ff @(posedge CLK) begin
        if (RESET) begin
            regs <= '0;
            p    <= '0;
        end else if (exec) begin
            if (ctrl.reg_wr) begin
                case (ctrl.dst)
                    cpu_pkg::REG_A: regs.a <= alu_out.result;
                    cpu_pkg::REG_X: regs.x <= alu_out.result;
                    cpu_pkg::REG_Y: regs.y <= alu_out.result;
                    default:        regs.s <= alu_out.result;   // TXS only
                endcase
            end
            if (ctrl.flag_wr)
                p <= alu_out.p;                             // New N V Z C
        end
    end

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_top (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   ce,          // Low freezes the core
    output logic [`CPU_ADDR_W-1:0] addr,
    input  logic [`CPU_DATA_W-1:0] din,
    output logic [`CPU_DATA_W-1:0] dout,
    output logic [`CPU_ADDR_W-1:0] wr_addr,
    output logic                   wreq
);

    cpu_pkg::ctrl_t         dec_ctrl;           // Decoded from din in FETCH
    cpu_pkg::ctrl_t         ctrl;               // Latched instruction
    logic                   exec;
    cpu_pkg::regs_t         regs;
    logic [`CPU_DATA_W-1:0] p;
    cpu_pkg::alu_out_t      alu_out;

    cpu_decode u_decode (
        .din  (din),
        .ctrl (dec_ctrl)
    );

    cpu_sequencer u_sequencer (
        .CLK      (CLK),
        .RESET    (RESET),
        .ce       (ce),
        .din      (din),
        .dec_ctrl (dec_ctrl),
        .p        (p),
        .alu_out  (alu_out),
        .ctrl     (ctrl),
        .exec     (exec),
        .addr     (addr),
        .wr_addr  (wr_addr),
        .dout     (dout),
        .wreq     (wreq)
    );

    cpu_alu u_alu (
        .ctrl    (ctrl),
        .regs    (regs),
        .p       (p),
        .din     (din),
        .alu_out (alu_out)
    );

    cpu_regfile u_regfile (
        .CLK     (CLK),
        .RESET   (RESET),
        .exec    (exec),
        .ctrl    (ctrl),
        .alu_out (alu_out),
        .regs    (regs),
        .p       (p)
    );

endmodule

//--- tb/tb_cpu_mem.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu_mem (
    input  logic                   CLK,
    input  logic [`CPU_ADDR_W-1:0] addr,        // Read address from the core
    output logic [`CPU_DATA_W-1:0] rdata,
    input  logic [`CPU_ADDR_W-1:0] wr_addr,
    input  logic [`CPU_DATA_W-1:0] wdata,
    input  logic                   wreq
);

    // ------------------------------------------------------------------
    // Flat 64 KiB array, loaded by the testbench before reset
    // ------------------------------------------------------------------

    logic [`CPU_DATA_W-1:0] mem [0:(1 << `CPU_ADDR_W) - 1];

    assign rdata = mem[addr];                   // Same-cycle read

    // Write accepted at the rising edge that sees wreq
    always @(posedge CLK) begin
        if (wreq) begin
            mem[wr_addr] <= wdata;
        end
    end

endmodule

//--- tb/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu;

    localparam int          NROWS     = 22;
    localparam int          LONGEST   = 4;              // Slowest instruction, in cycles
    localparam int          TIMEOUT   = 8 * NROWS * LONGEST;
    localparam logic [15:0] PROG_BASE = 16'h0200;
    localparam logic [1:0]  M_IMP     = 2'd0;
    localparam logic [1:0]  M_IMM     = 2'd1;
    localparam logic [1:0]  M_ZP      = 2'd2;
    localparam logic [1:0]  M_ABS     = 2'd3;

    typedef struct packed {
        logic [7:0] pre;        // Implied op ahead of the load, 00 for none
        logic [7:0] ld_op;      // LDA, LDX or LDY immediate
        logic [7:0] ld;
        logic [7:0] op;
        logic [1:0] mode;       // Operand placement of op
        logic [7:0] opnd;
        logic [7:0] st_op;      // STA, STX or STY zero page
        logic [7:0] br;         // Branch after the store, 00 for none
        logic       tk;         // Branch expected taken
        logic [7:0] exp;        // Expected stored byte
    } row_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  gap;       // ce-high cycles since the previous write
    } wr_t;

    logic                   CLK;
    logic                   RESET;
    logic                   ce;
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] din;
    logic [`CPU_DATA_W-1:0] dout;
    logic [`CPU_ADDR_W-1:0] wr_addr;
    logic                   wreq;

    row_t        tbl [NROWS];
    wr_t         exp_q [$];
    logic [15:0] bpc;           // Program build pointer
    int          acc;           // Cycles since the last expected write
    int          widx;
    int          cnt;
    int          last;
    int          tcount;
    int          pass;

    cpu_top UUT (
        .CLK     (CLK),
        .RESET   (RESET),
        .ce      (ce),
        .addr    (addr),
        .din     (din),
        .dout    (dout),
        .wr_addr (wr_addr),
        .wreq    (wreq)
    );

    tb_cpu_mem MEM (
        .CLK     (CLK),
        .addr    (addr),
        .rdata   (din),
        .wr_addr (wr_addr),
        .wdata   (dout),
        .wreq    (wreq)
    );

    initial CLK = 1'b0;
    always #20 CLK = ~CLK;

    // ------------------------------------------------------------------
    // Failure reporting and the value check
    // ------------------------------------------------------------------

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] want);
        if (got !== want)
            stop_run($sformatf("Fail %s got %h expected %h", name, got, want));
    endtask

    // ------------------------------------------------------------------
    // Stimulus table, expected bytes worked out by hand
    // ------------------------------------------------------------------

    task automatic load_table;
        //        pre    ld_op  ld     op     mode   opnd   st_op  br     tk    exp
        tbl[0]  = {8'h00, 8'hA9, 8'h5A, 8'h09, M_IMM, 8'h0F, 8'h85, 8'hD0, 1'b1, 8'h5F};
        tbl[1]  = {8'h00, 8'hA9, 8'hF0, 8'h25, M_ZP,  8'h3C, 8'h85, 8'h30, 1'b0, 8'h30};
        tbl[2]  = {8'h00, 8'hA9, 8'hFF, 8'h4D, M_ABS, 8'hFF, 8'h85, 8'hF0, 1'b1, 8'h00};
        tbl[3]  = {8'h18, 8'hA9, 8'h7F, 8'h69, M_IMM, 8'h01, 8'h85, 8'h70, 1'b1, 8'h80};
        tbl[4]  = {8'h38, 8'hA9, 8'hFF, 8'h65, M_ZP,  8'h01, 8'h85, 8'h90, 1'b0, 8'h01};
        tbl[5]  = {8'h38, 8'hA9, 8'h50, 8'hE9, M_IMM, 8'h10, 8'h85, 8'hB0, 1'b1, 8'h40};
        tbl[6]  = {8'h18, 8'hA9, 8'h10, 8'hED, M_ABS, 8'h20, 8'h85, 8'hB0, 1'b0, 8'hEF};
        tbl[7]  = {8'h00, 8'hA9, 8'h40, 8'hC9, M_IMM, 8'h40, 8'h85, 8'hF0, 1'b1, 8'h40};
        tbl[8]  = {8'h00, 8'hA9, 8'h30, 8'hC5, M_ZP,  8'h50, 8'h85, 8'h90, 1'b1, 8'h30};
        tbl[9]  = {8'hB8, 8'hA9, 8'h20, 8'hCD, M_ABS, 8'h10, 8'h85, 8'h50, 1'b1, 8'h20};
        tbl[10] = {8'h00, 8'hA2, 8'hFF, 8'hE8, M_IMP, 8'h00, 8'h86, 8'hF0, 1'b1, 8'h00};
        tbl[11] = {8'h00, 8'hA0, 8'h00, 8'h88, M_IMP, 8'h00, 8'h84, 8'h10, 1'b0, 8'hFF};
        tbl[12] = {8'h00, 8'hA2, 8'h7F, 8'hCA, M_IMP, 8'h00, 8'h86, 8'h00, 1'b0, 8'h7E};
        tbl[13] = {8'h00, 8'hA0, 8'h80, 8'hC8, M_IMP, 8'h00, 8'h84, 8'h30, 1'b1, 8'h81};
        tbl[14] = {8'h00, 8'hA9, 8'hC3, 8'hAA, M_IMP, 8'h00, 8'h86, 8'h30, 1'b1, 8'hC3};
        tbl[15] = {8'h00, 8'hA9, 8'h9C, 8'hA8, M_IMP, 8'h00, 8'h84, 8'h00, 1'b0, 8'h9C};
        tbl[16] = {8'h00, 8'hA2, 8'h3E, 8'h8A, M_IMP, 8'h00, 8'h85, 8'hD0, 1'b1, 8'h3E};
        tbl[17] = {8'h00, 8'hA0, 8'h05, 8'h98, M_IMP, 8'h00, 8'h85, 8'h10, 1'b1, 8'h05};
        tbl[18] = {8'h00, 8'hA2, 8'hA7, 8'h9A, M_IMP, 8'h00, 8'h86, 8'h30, 1'b1, 8'hA7};
        tbl[19] = {8'h00, 8'hA2, 8'h11, 8'hBA, M_IMP, 8'h00, 8'h86, 8'h10, 1'b0, 8'hA7};
        tbl[20] = {8'h00, 8'hA9, 8'h00, 8'hA6, M_ZP,  8'h6D, 8'h86, 8'h10, 1'b1, 8'h6D};
        tbl[21] = {8'h00, 8'hA9, 8'h00, 8'hAC, M_ABS, 8'h9E, 8'h84, 8'hD0, 1'b1, 8'h9E};
    endtask

    // ------------------------------------------------------------------
    // Program builder with cycle bookkeeping from the timing table
    // ------------------------------------------------------------------

    task automatic put(input logic [7:0] b);
        MEM.mem[bpc] = b;
        bpc = bpc + 16'd1;
    endtask

    task automatic expect_write(input logic [15:0] a, input logic [7:0] d);
        wr_t w;
        acc      = acc + 3;                                 // Zero-page store
        w.addr   = a;
        w.data   = d;
        w.gap    = acc[7:0];
        exp_q.push_back(w);
        acc      = 0;
    endtask

    task automatic branch(input logic [7:0] op, input logic taken);
        logic [15:0] target;
        put(op);
        put(8'h02);                                         // Over the marker store
        target = bpc + 16'd2;
        if (!taken)
            acc = acc + 2;
        else if (target[15:8] != bpc[15:8])
            acc = acc + 4;                                  // Page crossed
        else
            acc = acc + 3;
    endtask

    task automatic build_program;
        row_t r;
        for (int a = 0; a < 65536; a++)
            MEM.mem[a] = a[15:8] ^ a[7:0] ^ 8'h3C;          // Background pattern
        MEM.mem[`CPU_RESET_VECTOR]     = PROG_BASE[7:0];
        MEM.mem[`CPU_RESET_VECTOR + 1] = PROG_BASE[15:8];
        bpc = PROG_BASE;
        acc = 3;                                            // Reset sequence
        for (int i = 0; i < NROWS; i++) begin
            r = tbl[i];
            if (r.pre != 8'h00) begin
                put(r.pre);
                acc = acc + 2;
            end
            put(r.ld_op);
            put(r.ld);
            put(r.op);
            acc = acc + 4;                                  // Load plus a two-cycle op
            case (r.mode)
                M_IMM: put(r.opnd);
                M_ZP: begin
                    put(8'h80 + i[7:0]);
                    MEM.mem[16'h0080 + i] = r.opnd;
                    acc = acc + 1;
                end
                M_ABS: begin
                    put(8'h80 + i[7:0]);
                    put(8'h04);
                    MEM.mem[16'h0480 + i] = r.opnd;
                    acc = acc + 2;
                end
                default: ;
            endcase
            put(r.st_op);
            put(i[7:0]);
            expect_write(i, r.exp);
            if (r.br != 8'h00) begin
                branch(r.br, r.tk);
                put(r.st_op);                               // Marker on the fall-through path
                put(8'h40 + i[7:0]);
                if (!r.tk)
                    expect_write(16'h0040 + i, r.exp);
            end
        end
        put(8'hA9);                                         // LDA #E5
        put(8'hE5);
        put(8'h38);                                         // SEC
        put(8'h4C);                                         // JMP 03FC
        put(8'hFC);
        put(8'h03);
        acc = acc + 7;
        bpc = 16'h03FC;
        branch(8'hB0, 1'b1);                                // BCS into page 04
        put(8'h85);                                         // Skipped store
        put(8'h7E);
        put(8'h85);
        put(8'h7F);
        expect_write(16'h007F, 8'hE5);
        put(8'h4C);                                         // Park on itself
        put(8'h02);
        put(8'h04);
    endtask

    // ------------------------------------------------------------------
    // Bus monitor, sampled mid-cycle
    // ------------------------------------------------------------------

    task automatic record_write;
        wr_t w;
        if (widx >= exp_q.size()) begin
            stop_run("A write arrived after the last expected one");
        end else begin
            w = exp_q[widx];
            check("wr_addr", wr_addr, w.addr);
            check("dout", dout, w.data);
            if (pass == 0)
                check("write_gap", cnt - last, w.gap);
            last = cnt;
            widx = widx + 1;
        end
    endtask

    always @(negedge CLK) begin
        tcount = tcount + 1;
        if (tcount > TIMEOUT)
            stop_run("The run timed out before all expected writes were seen");
        if (wreq === 1'b1 && ce !== 1'b1)
            stop_run("Write request was high while ce was low");
        if (RESET) begin
            if (wreq === 1'b1)
                stop_run("Write request was high during reset");
            cnt  = 0;
            last = 0;
        end else if (ce) begin
            if (cnt == 3)
                check("addr", addr, PROG_BASE);             // First fetch
            if (wreq)
                record_write();
            cnt = cnt + 1;
        end
    end

    // ------------------------------------------------------------------
    // Two passes, ce held high then random stalls
    // ------------------------------------------------------------------

    initial begin
        void'($urandom(32'he6c50d9c));
        RESET  = 1'b1;
        ce     = 1'b1;
        widx   = 0;
        tcount = 0;
        pass   = 0;
        load_table();
        build_program();
        for (pass = 0; pass < 2; pass++) begin
            widx   = 0;
            tcount = 0;
            RESET  = 1'b1;
            ce     = 1'b1;
            repeat (5) @(posedge CLK);
            #2 RESET = 1'b0;
            while (widx < exp_q.size()) begin
                @(posedge CLK);
                #2 ce = (pass == 0) || ($urandom % 4 != 0);
            end
        end
        $display("All tests passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_decode.sv
logic/cpu_sequencer.sv
logic/cpu_alu.sv
logic/cpu_regfile.sv
logic/cpu_top.sv
tb/tb_cpu_mem.sv
tb/tb_cpu.sv
